// File: flist.f
hw/cmd_pkg.sv
hw/video_pkg.sv
hw/reg_bus_if.sv
hw/timing_if.sv
hw/cmd_decoder.sv
hw/video_regs.sv
hw/video_timing.sv
hw/pixel_formatter.sv
hw/hdmi_ctrl_top.sv
test/hdmi_ctrl_properties.sv
test/tb_hdmi_ctrl.sv

// File: test/tb_hdmi_ctrl.sv
// HDMI controller testbench
`timescale 1ns/1ps

module tb_hdmi_ctrl
	import cmd_pkg::*;
	import video_pkg::*;
();

	localparam int NUM_TESTS  = 6;
	localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;
	localparam int MAX_CYCLES = 4 * (NUM_TESTS * FRAME_CYC * 4);
	localparam int HS_LIMIT   = 20;

	logic                  mclk = 1'b0;
	logic                  rst_n;
	logic                  cmd_req;
	cmd_op_t               cmd_op;
	reg_addr_t             cmd_addr;
	logic [CMD_DATA_W-1:0] cmd_wdata;
	logic                  cmd_ack;
	logic [CMD_DATA_W-1:0] cmd_rdata;
	logic                  cmd_err;
	logic                  hdmi_de;
	logic                  hdmi_hsync;
	logic                  hdmi_vsync;
	pixel_t                hdmi_data;
	logic                  intr;

	// Reference register image
	logic [2:0]  m_ctrl  = '0;
	pixel_t      m_color = '0;
	logic [7:0]  m_irq   = '0;
	logic [31:0] lfsr    = 32'ha0f11ce5;

	// Raster position tracker
	int   pos_x    = 0;
	int   pos_y    = 0;
	logic px_watch = 1'b0;
	int   px_count = 0;

	// Scoreboard
	int errors    = 0;
	int checks    = 0;
	int test_num  = 0;
	int test_base = 0;
	int cycles    = 0;

	hdmi_ctrl_top UUT (.*);

	// 100 ns clock
	always #50 mclk = ~mclk;

	// ==============================
	// Run limit
	// ==============================
	always @(posedge mclk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped: no completion within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Model pixel at an active position
	function automatic pixel_t expected_pixel(input int x, input int y);
		pixel_t p;
		case (pattern_t'(m_ctrl[2:1]))
			PAT_RAMP: begin
				p.r = 8'(x * 32);
				p.g = 8'(y * 64);
				p.b = 8'h80;
			end
			PAT_CHECKER: p = ((x ^ y) & 1) ? pixel_t'(~m_color) : m_color;
			default:     p = m_color;
		endcase
		return p;
	endfunction

	// Expected readback, zero-extended
	function automatic logic [CMD_DATA_W-1:0] reg_value(input reg_addr_t addr);
		case (addr)
			REG_CTRL:       return 24'(m_ctrl);
			REG_COLOR:      return m_color;
			REG_IRQ_FRAMES: return 24'(m_irq);
			default:        return '0;
		endcase
	endfunction

	// ==============================
	// Compare tasks
	// ==============================
	task automatic data_compare(input string name, input logic [CMD_DATA_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic flag_compare(input string name, input logic got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic pixel_compare(input pixel_t got, exp, input int x, y);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: hdmi_data got 0x%h expected 0x%h at (%0d,%0d)", got, exp, x, y);
		end
	endtask

	task automatic count_compare(input string name, input int got, exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Per-test summary line
	task automatic test_done(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors - test_base);
		test_base = errors;
	endtask

	// ==============================
	// Host handshake
	// ==============================
	task automatic run_cmd(input cmd_op_t op, input reg_addr_t addr,
		input logic [CMD_DATA_W-1:0] wdata,
		output logic [CMD_DATA_W-1:0] rdata, output logic err);
		int lat;
		@(posedge mclk);
		cmd_req   <= 1'b1;
		cmd_op    <= op;
		cmd_addr  <= addr;
		cmd_wdata <= wdata;
		lat = 0;
		@(negedge mclk);
		while (!cmd_ack && lat < HS_LIMIT) begin
			@(negedge mclk);
			lat++;
		end
		// One edge to sample req, then ACK_DELAY
		if (!cmd_ack) begin
			errors++;
			$display("Host command got no ack within %0d cycles", HS_LIMIT);
		end else begin
			count_compare("ack latency", lat, ACK_DELAY + 1);
		end
		rdata = cmd_rdata;
		err   = cmd_err;
		@(posedge mclk);
		cmd_req <= 1'b0;
		lat = 0;
		@(negedge mclk);
		while (cmd_ack && lat < HS_LIMIT) begin
			@(negedge mclk);
			lat++;
		end
		if (cmd_ack) begin
			errors++;
			$display("cmd_ack stayed high after cmd_req dropped");
		end
	endtask

	task automatic write_reg(input reg_addr_t addr, input logic [CMD_DATA_W-1:0] data);
		logic [CMD_DATA_W-1:0] rd;
		logic                  err;
		run_cmd(OP_WRITE, addr, data, rd, err);
		flag_compare("cmd_err", err, 1'b0);
		case (addr)
			REG_CTRL:       m_ctrl  = data[2:0];
			REG_COLOR:      m_color = pixel_t'(data);
			REG_IRQ_FRAMES: m_irq   = data[7:0];
			default: ;
		endcase
	endtask

	task automatic read_reg(input reg_addr_t addr, output logic [CMD_DATA_W-1:0] data);
		logic err;
		run_cmd(OP_READ, addr, '0, data, err);
		flag_compare("cmd_err", err, 1'b0);
	endtask

	task automatic read_check(input reg_addr_t addr, input logic [CMD_DATA_W-1:0] exp);
		logic [CMD_DATA_W-1:0] rd;
		read_reg(addr, rd);
		data_compare("cmd_rdata", rd, exp);
	endtask

	// Clear enable, restart the tracker at (0,0)
	task automatic video_off();
		write_reg(REG_CTRL, {21'd0, m_ctrl[2:1], 1'b0});
		@(posedge mclk);
		pos_x = 0;
		pos_y = 0;
	endtask

	task automatic wait_vsync_fall();
		int n;
		n = 0;
		@(negedge mclk);
		while (!hdmi_vsync && n < 2 * FRAME_CYC) begin
			@(negedge mclk);
			n++;
		end
		while (hdmi_vsync && n < 2 * FRAME_CYC) begin
			@(negedge mclk);
			n++;
		end
		if (n >= 2 * FRAME_CYC) begin
			errors++;
			$display("No falling vsync within two frames");
		end
	endtask

	// ==============================
	// Pixel monitor
	// ==============================
	// Column from de count, row from de falls, frame restart on vsync
	always @(negedge mclk) begin
		if (rst_n) begin
			if (hdmi_vsync) begin
				pos_x = 0;
				pos_y = 0;
			end else if (hdmi_de) begin
				if (px_watch) begin
					pixel_compare(hdmi_data, expected_pixel(pos_x, pos_y), pos_x, pos_y);
					px_count++;
				end
				pos_x++;
			end else if (pos_x != 0) begin
				pos_x = 0;
				pos_y++;
			end
		end
	end

	// ==============================
	// Tests
	// ==============================
	task automatic registers_readback();
		reg_addr_t addr;
		int        k;
		for (k = 0; k < 8; k++) begin
			addr = reg_addr_t'(2'(rand_bits(2) % 3));
			write_reg(addr, 24'(rand_bits(24)));
			read_check(addr, reg_value(addr));
		end
		test_done("register access");
	endtask

	task automatic error_responses();
		logic [CMD_DATA_W-1:0] rd;
		logic                  err;
		video_off();
		// Frame count cleared, held at 0 while video is off
		run_cmd(OP_IRQ_CLR, REG_CTRL, '0, rd, err);
		flag_compare("cmd_err", err, 1'b0);
		// Read-only target, nonzero data
		run_cmd(OP_WRITE, REG_FRAME_CNT, 24'(rand_bits(24)) | 24'd1, rd, err);
		flag_compare("cmd_err", err, 1'b1);
		// Spare opcode aimed at a writable register
		run_cmd(cmd_op_t'(2'd3), reg_addr_t'(2'(rand_bits(2) % 3)), 24'(rand_bits(24)), rd, err);
		flag_compare("cmd_err", err, 1'b1);
		read_check(REG_CTRL, reg_value(REG_CTRL));
		read_check(REG_COLOR, reg_value(REG_COLOR));
		read_check(REG_IRQ_FRAMES, reg_value(REG_IRQ_FRAMES));
		read_check(REG_FRAME_CNT, '0);
		test_done("error responses");
	endtask

	task automatic raster_shape();
		int k;
		int de_cnt   = 0;
		int de_run   = 0;
		int de_lines = 0;
		int hs_run   = 0;
		int hs_lines = 0;
		int vs_cnt   = 0;
		video_off();
		write_reg(REG_CTRL, {21'd0, m_ctrl[2:1], 1'b1});
		// One whole frame from the first line after vsync
		wait_vsync_fall();
		for (k = 0; k < FRAME_CYC; k++) begin
			if (hdmi_de) begin
				de_cnt++;
				de_run++;
			end else if (de_run != 0) begin
				count_compare("de run length", de_run, H_ACTIVE);
				de_lines++;
				de_run = 0;
			end
			if (hdmi_hsync) begin
				hs_run++;
			end else if (hs_run != 0) begin
				count_compare("hsync run length", hs_run, H_SYNC);
				hs_lines++;
				hs_run = 0;
			end
			if (hdmi_vsync)
				vs_cnt++;
			@(negedge mclk);
		end
		count_compare("de cycles per frame", de_cnt, H_ACTIVE * V_ACTIVE);
		count_compare("active lines", de_lines, V_ACTIVE);
		count_compare("hsync lines", hs_lines, V_TOTAL);
		count_compare("vsync cycles", vs_cnt, V_SYNC * H_TOTAL);
		test_done("raster shape");
	endtask

	task automatic pixel_patterns();
		logic [1:0] pat;
		int         k;
		// Three named patterns, then a random code
		for (k = 0; k < 4; k++) begin
			pat = (k < 3) ? 2'(k) : 2'(rand_bits(2));
			video_off();
			write_reg(REG_COLOR, 24'(rand_bits(24)));
			write_reg(REG_CTRL, {21'd0, pat, 1'b1});
			@(posedge mclk);
			px_count = 0;
			px_watch = 1'b1;
			wait_vsync_fall();
			wait_vsync_fall();
			@(posedge mclk);
			px_watch = 1'b0;
			if (px_count < H_ACTIVE * V_ACTIVE) begin
				errors++;
				$display("Only %0d active pixels seen for pattern %0d", px_count, pat);
			end
		end
		test_done("pixel patterns");
	endtask

	task automatic frame_interrupt();
		logic [CMD_DATA_W-1:0] rd;
		logic                  err;
		logic                  prev;
		int                    n;
		int                    falls;
		int                    cyc;
		video_off();
		n = 1 + int'(rand_bits(2));
		write_reg(REG_IRQ_FRAMES, 24'(n));
		run_cmd(OP_IRQ_CLR, REG_CTRL, '0, rd, err);
		flag_compare("cmd_err", err, 1'b0);
		flag_compare("intr", intr, 1'b0);
		write_reg(REG_CTRL, {21'd0, m_ctrl[2:1], 1'b1});
		falls = 0;
		cyc   = 0;
		prev  = hdmi_vsync;
		while (!intr && cyc < (n + 2) * FRAME_CYC) begin
			@(negedge mclk);
			if (prev && !hdmi_vsync)
				falls++;
			prev = hdmi_vsync;
			cyc++;
		end
		if (!intr) begin
			errors++;
			$display("Interrupt did not rise within %0d frames", n + 2);
		end else begin
			count_compare("vsync falls before intr", falls, n);
		end
		// Clear well before the next frame end
		run_cmd(OP_IRQ_CLR, REG_CTRL, '0, rd, err);
		flag_compare("cmd_err", err, 1'b0);
		flag_compare("intr", intr, 1'b0);
		read_check(REG_FRAME_CNT, '0);
		test_done("frame interrupt");
	endtask

	task automatic disable_blanking();
		int k;
		int bad = 0;
		write_reg(REG_CTRL, {21'd0, m_ctrl[2:1], 1'b1});
		video_off();
		for (k = 0; k < FRAME_CYC; k++) begin
			@(negedge mclk);
			if (hdmi_de || hdmi_hsync || hdmi_vsync || (hdmi_data != '0))
				bad++;
		end
		count_compare("active outputs while disabled", bad, 0);
		test_done("disable blanking");
	endtask

	// ==============================
	// Sequence
	// ==============================
	initial begin
		int total;
		cmd_req   <= 1'b0;
		cmd_op    <= OP_READ;
		cmd_addr  <= REG_CTRL;
		cmd_wdata <= '0;
		rst_n     <= 1'b0;
		repeat (3) @(posedge mclk);
		rst_n <= 1'b1;
		@(posedge mclk);
		registers_readback();
		error_responses();
		raster_shape();
		pixel_patterns();
		frame_interrupt();
		disable_blanking();
		total = errors + UUT.u_props.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			test_num, checks, errors, UUT.u_props.fail_cnt);
		if (total == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: test/hdmi_ctrl_properties.sv
// Controller protocol assertions
`timescale 1ns/1ps

module hdmi_ctrl_properties
	import video_pkg::*;
(
	input logic   mclk,
	input logic   rst_n,
	input logic   cmd_req,
	input logic   cmd_ack,
	input logic   hdmi_de,
	input logic   hdmi_hsync,
	input pixel_t hdmi_data
);

	// Running count of assertion failures
	int fail_cnt = 0;

	// Ack only answers a pending request
	ack_needs_req: assert property (@(posedge mclk) disable iff (!rst_n)
		$rose(cmd_ack) |-> cmd_req)
	else begin
		$error("cmd_ack rose while cmd_req was low");
		fail_cnt++;
	end

	// Sync sits in the blanking interval
	hsync_outside_de: assert property (@(posedge mclk) disable iff (!rst_n)
		!(hdmi_hsync && hdmi_de))
	else begin
		$error("hdmi_hsync and hdmi_de high together");
		fail_cnt++;
	end

	// Blanked pixels carry no data
	data_blanked: assert property (@(posedge mclk) disable iff (!rst_n)
		!hdmi_de |-> (hdmi_data == '0))
	else begin
		$error("hdmi_data nonzero outside the active area");
		fail_cnt++;
	end

endmodule

// Attach to the controller top
bind hdmi_ctrl_top hdmi_ctrl_properties u_props (
	.mclk       (mclk),
	.rst_n      (rst_n),
	.cmd_req    (cmd_req),
	.cmd_ack    (cmd_ack),
	.hdmi_de    (hdmi_de),
	.hdmi_hsync (hdmi_hsync),
	.hdmi_data  (hdmi_data)
);

// File: hw/hdmi_ctrl_top.sv
// HDMI scan-out controller top
`timescale 1ns/1ps

module hdmi_ctrl_top
	import cmd_pkg::*;
	import video_pkg::*;
(
	input  logic                  mclk,
	input  logic                  rst_n,
	// Host command port
	input  logic                  cmd_req,
	input  cmd_op_t               cmd_op,
	input  reg_addr_t             cmd_addr,
	input  logic [CMD_DATA_W-1:0] cmd_wdata,
	output logic                  cmd_ack,
	output logic [CMD_DATA_W-1:0] cmd_rdata,
	output logic                  cmd_err,
	// Video out
	output logic                  hdmi_de,
	output logic                  hdmi_hsync,
	output logic                  hdmi_vsync,
	output pixel_t                hdmi_data,
	// Frame interrupt
	output logic                  intr
);

	// Control wires from the register file
	logic     enable;
	pattern_t pattern;
	pixel_t   color;
	logic     frame_end;

	// Internal buses
	reg_bus_if reg_bus ();
	timing_if  tim ();

	// Host handshake
	cmd_decoder u_decoder (
		.mclk      (mclk),
		.rst_n     (rst_n),
		.cmd_req   (cmd_req),
		.cmd_op    (cmd_op),
		.cmd_addr  (cmd_addr),
		.cmd_wdata (cmd_wdata),
		.cmd_ack   (cmd_ack),
		.cmd_rdata (cmd_rdata),
		.cmd_err   (cmd_err),
		.bus       (reg_bus)
	);

	// Registers and frame interrupt
	video_regs u_regs (
		.mclk      (mclk),
		.rst_n     (rst_n),
		.frame_end (frame_end),
		.bus       (reg_bus),
		.enable    (enable),
		.pattern   (pattern),
		.color     (color),
		.intr      (intr)
	);

	// Raster counters
	video_timing u_timing (
		.mclk      (mclk),
		.rst_n     (rst_n),
		.enable    (enable),
		.frame_end (frame_end),
		.tif       (tim)
	);

	// Pixel output stage
	pixel_formatter u_formatter (
		.mclk       (mclk),
		.rst_n      (rst_n),
		.enable     (enable),
		.pattern    (pattern),
		.color      (color),
		.tif        (tim),
		.hdmi_de    (hdmi_de),
		.hdmi_hsync (hdmi_hsync),
		.hdmi_vsync (hdmi_vsync),
		.hdmi_data  (hdmi_data)
	);

endmodule

// File: hw/pixel_formatter.sv
// Pixel pattern formatter
`timescale 1ns/1ps

module pixel_formatter
	import video_pkg::*;
(
	input  logic     mclk,
	input  logic     rst_n,
	input  logic     enable,
	input  pattern_t pattern,
	input  pixel_t   color,
	timing_if.sink   tif,
	output logic     hdmi_de,
	output logic     hdmi_hsync,
	output logic     hdmi_vsync,
	output pixel_t   hdmi_data
);

	pixel_t ramp;
	pixel_t pix;
	logic   odd_cell;

	// ==============================
	// Pattern generation
	// ==============================

	// Horizontal red ramp, vertical green ramp
	always_comb begin
		ramp.r = 8'(tif.hpos) << RAMP_H_SHIFT;
		ramp.g = 8'(tif.vpos) << RAMP_V_SHIFT;
		ramp.b = RAMP_BLUE;
	end

	// Single-pixel checker cells
	assign odd_cell = tif.hpos[0] ^ tif.vpos[0];

	// Pattern select
	always_comb begin
		case (pattern)
			PAT_RAMP:    pix = ramp;
			PAT_CHECKER: pix = odd_cell ? pixel_t'(~color) : color;
			default:     pix = color;	// solid and the spare code
		endcase
	end

	// ==============================
	// Output stage
	// ==============================
	// One cycle behind the counters, blanked when disabled
	always_ff @(posedge mclk) begin
		if (!rst_n || !enable) begin
			hdmi_de    <= 1'b0;
			hdmi_hsync <= 1'b0;
			hdmi_vsync <= 1'b0;
			hdmi_data  <= '0;
		end else begin
			hdmi_de    <= tif.de;
			hdmi_hsync <= tif.hsync;
			hdmi_vsync <= tif.vsync;
			// Zero outside the active area
			hdmi_data  <= tif.de ? pix : '0;
		end
	end

endmodule

// File: hw/video_timing.sv
// Raster timing generator
`timescale 1ns/1ps

module video_timing
	import video_pkg::*;
(
	input  logic      mclk,
	input  logic      rst_n,
	input  logic      enable,
	output logic      frame_end,
	timing_if.source  tif
);

	logic [H_CNT_W-1:0] h_cnt;
	logic [V_CNT_W-1:0] v_cnt;
	logic               h_last;
	logic               v_last;

	// Wrap points
	assign h_last = (h_cnt == H_CNT_W'(H_TOTAL - 1));
	assign v_last = (v_cnt == V_CNT_W'(V_TOTAL - 1));

	// ==============================
	// Position counters
	// ==============================
	// Held at (0,0) while disabled
	always_ff @(posedge mclk) begin
		if (!rst_n || !enable) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
			v_cnt <= v_last ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// ==============================
	// Boundary decode
	// ==============================
	assign tif.hpos = h_cnt;
	assign tif.vpos = v_cnt;

	// Active area at the start of line and frame
	assign tif.de = (h_cnt < H_CNT_W'(H_ACTIVE)) && (v_cnt < V_CNT_W'(V_ACTIVE));

	// Sync after front porch
	assign tif.hsync = (h_cnt >= H_CNT_W'(H_SYNC_START)) &&
		(h_cnt < H_CNT_W'(H_SYNC_END));
	assign tif.vsync = (v_cnt >= V_CNT_W'(V_SYNC_START)) &&
		(v_cnt < V_CNT_W'(V_SYNC_END));

	// Last position of the frame
	assign frame_end = h_last && v_last;

endmodule

// File: hw/video_regs.sv
// Video control registers
`timescale 1ns/1ps

module video_regs
	import cmd_pkg::*;
	import video_pkg::*;
(
	input  logic     mclk,
	input  logic     rst_n,
	input  logic     frame_end,
	reg_bus_if.regs  bus,
	output logic     enable,
	output pattern_t pattern,
	output pixel_t   color,
	output logic     intr
);

	logic [FRAME_W-1:0] irq_frames;
	logic [FRAME_W-1:0] frame_cnt;
	logic               wr_en;
	logic               irq_clr;

	// Decoded strobes
	assign wr_en   = bus.acc && (bus.op == OP_WRITE);
	assign irq_clr = bus.acc && (bus.op == OP_IRQ_CLR);

	// Frame count is read only
	assign bus.err = (bus.op == OP_WRITE) && (bus.addr == REG_FRAME_CNT);

	// Read mux, zero-extended to the bus width
	always_comb begin
		case (bus.addr)
			REG_CTRL:       bus.rdata = CMD_DATA_W'({pattern, enable});
			REG_COLOR:      bus.rdata = CMD_DATA_W'(color);
			REG_IRQ_FRAMES: bus.rdata = CMD_DATA_W'(irq_frames);
			default:        bus.rdata = CMD_DATA_W'(frame_cnt);
		endcase
	end

	// ==============================
	// Writable registers
	// ==============================
	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			enable     <= 1'b0;
			pattern    <= PAT_SOLID;
			color      <= '0;
			irq_frames <= '0;
		end else if (wr_en) begin
			case (bus.addr)
				REG_CTRL: begin
					enable  <= bus.wdata[CTRL_EN_BIT];
					pattern <= pattern_t'(bus.wdata[CTRL_PAT_MSB:CTRL_PAT_LSB]);
				end
				REG_COLOR:      color      <= pixel_t'(bus.wdata);
				REG_IRQ_FRAMES: irq_frames <= bus.wdata[FRAME_W-1:0];
				default: ;
			endcase
		end
	end

	// ==============================
	// Frame counter and interrupt
	// ==============================
	always_ff @(posedge mclk) begin
		if (!rst_n || irq_clr) begin
			frame_cnt <= '0;
			intr      <= 1'b0;
		end else begin
			if (frame_end)
				frame_cnt <= frame_cnt + 1'b1;
			// Sticky once the threshold is met
			if ((irq_frames != '0) && (frame_cnt == irq_frames))
				intr <= 1'b1;
		end
	end

endmodule

// File: hw/cmd_decoder.sv
// Host command decoder
`timescale 1ns/1ps

module cmd_decoder
	import cmd_pkg::*;
(
	input  logic                  mclk,
	input  logic                  rst_n,
	// Host port
	input  logic                  cmd_req,
	input  cmd_op_t               cmd_op,
	input  reg_addr_t             cmd_addr,
	input  logic [CMD_DATA_W-1:0] cmd_wdata,
	output logic                  cmd_ack,
	output logic [CMD_DATA_W-1:0] cmd_rdata,
	output logic                  cmd_err,
	// Register file
	reg_bus_if.decoder            bus
);

	// Handshake sequence
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		ACK,
		WAIT_LOW
	} state_t;

	state_t     state;
	logic [1:0] dly_cnt;
	logic       op_legal;

	// Fourth opcode is illegal
	assign op_legal = cmd_op inside {OP_READ, OP_WRITE, OP_IRQ_CLR};

	// Fields held stable by the host until ack
	assign bus.op    = cmd_op;
	assign bus.addr  = cmd_addr;
	assign bus.wdata = cmd_wdata;

	// One strobe per command, none for a bad opcode
	assign bus.acc = (state == ACCESS) && op_legal;

	// ==============================
	// Handshake FSM
	// ==============================
	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			state   <= IDLE;
			dly_cnt <= '0;
			cmd_ack <= 1'b0;
			cmd_err <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (cmd_req)
						state <= ACCESS;
				end
				ACCESS: begin
					// Response captured on the strobe edge
					cmd_err <= op_legal ? bus.err : 1'b1;
					dly_cnt <= '0;
					state   <= ACK;
				end
				ACK: begin
					// Pad out to ACK_DELAY after req was seen
					if (dly_cnt == 2'(ACK_DELAY - 2)) begin
						cmd_ack <= 1'b1;
						state   <= WAIT_LOW;
					end else begin
						dly_cnt <= dly_cnt + 2'd1;
					end
				end
				WAIT_LOW: begin
					// Ack held until req is seen low
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						state   <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Read data latch, valid while ack is high
	always_ff @(posedge mclk) begin
		if (state == ACCESS)
			cmd_rdata <= op_legal ? bus.rdata : '0;
	end

endmodule

// File: hw/timing_if.sv
// Raster position and sync bus
`timescale 1ns/1ps

interface timing_if
	import video_pkg::*;
();

	// Decoded raster flags
	logic de;
	logic hsync;
	logic vsync;

	// Current counter position
	logic [H_CNT_W-1:0] hpos;
	logic [V_CNT_W-1:0] vpos;

	// Timing generator
	modport source (output de, hsync, vsync, hpos, vpos);

	// Pixel formatter
	modport sink (input de, hsync, vsync, hpos, vpos);

endinterface

// File: hw/reg_bus_if.sv
// Register access bus
`timescale 1ns/1ps

interface reg_bus_if
	import cmd_pkg::*;
();

	// Single-cycle access strobe and command fields
	logic                  acc;
	cmd_op_t               op;
	reg_addr_t             addr;
	logic [CMD_DATA_W-1:0] wdata;

	// Combinational response, same cycle as acc
	logic [CMD_DATA_W-1:0] rdata;
	logic                  err;

	// Command side
	modport decoder (output acc, op, addr, wdata, input rdata, err);

	// Register file side
	modport regs (input acc, op, addr, wdata, output rdata, err);

endinterface

// File: hw/video_pkg.sv
// Raster timing and pixel types
package video_pkg;

	// ==============================
	// Horizontal timing
	// ==============================

	// Sizes in mclk cycles
	localparam int H_ACTIVE = 8;
	localparam int H_FRONT  = 2;
	localparam int H_SYNC   = 2;
	localparam int H_BACK   = 2;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Sync window inside the line
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;

	// ==============================
	// Vertical timing
	// ==============================

	// Sizes in lines
	localparam int V_ACTIVE = 4;
	localparam int V_FRONT  = 1;
	localparam int V_SYNC   = 1;
	localparam int V_BACK   = 1;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Sync window inside the frame
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	// Counter widths
	localparam int H_CNT_W = 4;
	localparam int V_CNT_W = 4;

	// Ramp pattern scaling
	localparam int         RAMP_H_SHIFT = 5;
	localparam int         RAMP_V_SHIFT = 6;
	localparam logic [7:0] RAMP_BLUE    = 8'h80;

	// Code 2'd3 falls back to solid
	typedef enum logic [1:0] {
		PAT_SOLID   = 2'd0,
		PAT_RAMP    = 2'd1,
		PAT_CHECKER = 2'd2
	} pattern_t;

	// 24-bit RGB, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

endpackage

// File: hw/cmd_pkg.sv
// Host command definitions
package cmd_pkg;

	// ==============================
	// Host port sizes
	// ==============================

	// Write and read data width
	localparam int CMD_DATA_W = 24;

	// Cycles from req sampled high to ack rising
	localparam int ACK_DELAY = 2;

	// Frame counter and IRQ threshold width
	localparam int FRAME_W = 8;

	// CTRL register fields
	localparam int CTRL_EN_BIT  = 0;
	localparam int CTRL_PAT_LSB = 1;
	localparam int CTRL_PAT_MSB = 2;

	// ==============================
	// Opcodes and register map
	// ==============================

	// Code 2'd3 unassigned, rejected by the decoder
	typedef enum logic [1:0] {
		OP_READ    = 2'd0,
		OP_WRITE   = 2'd1,
		OP_IRQ_CLR = 2'd2
	} cmd_op_t;

	// Register addresses
	typedef enum logic [1:0] {
		REG_CTRL       = 2'd0,	// enable and pattern
		REG_COLOR      = 2'd1,	// solid colour, 24 bits
		REG_IRQ_FRAMES = 2'd2,	// interrupt threshold
		REG_FRAME_CNT  = 2'd3	// read only
	} reg_addr_t;

endpackage
